// File: design/hci_ecc_pkg.sv
`default_nettype none

package hci_ecc_pkg;

  // data path geometry
  localparam int unsigned DataWidth = 32;
  localparam int unsigned EccWidth  = 7;
  localparam int unsigned BeWidth   = DataWidth / 8;
  // byte address carried on the memory bus
  localparam int unsigned AddrWidth = 16;

  // bank geometry, word index taken from add[9:2]
  localparam int unsigned BankDepth = 256;
  localparam int unsigned IdxWidth  = $clog2(BankDepth);
  localparam int unsigned AddrLsb   = $clog2(BeWidth);

  // hsiao 39/32 parity masks, one per check bit
  // every data column has weight 3 and no two columns are equal
  localparam logic [DataWidth-1:0] EccMask [EccWidth] = '{
    32'h0000_7FFF,
    32'h01FF_801F,
    32'h7E07_81E1,
    32'h8E38_8E22,
    32'hB2C9_3244,
    32'hD552_5488,
    32'h69A4_6910
  };

  // decode result class
  typedef enum logic [1:0] {
    ErrNone   = 2'd0,
    ErrCorr   = 2'd1,
    ErrUncorr = 2'd2
  } ecc_err_e;

  // protected request, check bits ride in the upper user bits
  typedef struct packed {
    logic                 req;
    logic [AddrWidth-1:0] add;
    // low means write
    logic                 wen;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] data;
    logic [EccWidth-1:0]  ecc;
  } ecc_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 r_valid;
    logic [DataWidth-1:0] r_data;
    logic [EccWidth-1:0]  r_ecc;
  } ecc_rsp_t;

  // plain request towards the bank
  typedef struct packed {
    logic                 req;
    logic [AddrWidth-1:0] add;
    logic                 wen;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic                 r_valid;
    logic [DataWidth-1:0] r_data;
  } mem_rsp_t;

  // one decode event per accepted write
  typedef struct packed {
    logic                 valid;
    ecc_err_e             err;
    logic [EccWidth-1:0]  syndrome;
    logic [AddrWidth-1:0] add;
  } ecc_evt_t;

  // status register block
  localparam int unsigned ApbAddrWidth = 8;
  localparam int unsigned ApbDataWidth = 32;
  localparam int unsigned CntWidth     = 16;

  localparam logic [ApbAddrWidth-1:0] RegCorrCnt   = 8'h00;
  localparam logic [ApbAddrWidth-1:0] RegUncorrCnt = 8'h04;
  localparam logic [ApbAddrWidth-1:0] RegLastSyn   = 8'h08;
  localparam logic [ApbAddrWidth-1:0] RegLastAddr  = 8'h0C;
  localparam logic [ApbAddrWidth-1:0] RegClear     = 8'h10;

endpackage

`default_nettype wire

// File: design/secded_39_32_enc.sv
`timescale 1ns/1ps
`default_nettype none

// hsiao 39/32 encoder
// check bits only, the data passes alongside untouched
module secded_39_32_enc (
  input  logic [hci_ecc_pkg::DataWidth-1:0] data_i,
  output logic [hci_ecc_pkg::EccWidth-1:0]  ecc_o
);

  // masked data, one row per check bit
  logic [hci_ecc_pkg::DataWidth-1:0] masked [hci_ecc_pkg::EccWidth];

  // select the data bits that feed each check bit
  always_comb begin
    for (int k = 0; k < hci_ecc_pkg::EccWidth; k++) begin
      masked[k] = data_i & hci_ecc_pkg::EccMask[k];
    end
  end

  // even parity over each selection
  always_comb begin
    for (int k = 0; k < hci_ecc_pkg::EccWidth; k++) begin
      ecc_o[k] = ^masked[k];
    end
  end

  // all-zero data gives all-zero check bits
  // so a freshly cleared bank reads back as a clean codeword

endmodule

`default_nettype wire

// File: design/secded_39_32_dec.sv
`timescale 1ns/1ps
`default_nettype none

// hsiao 39/32 decoder
// single error correct, double error detect
module secded_39_32_dec (
  input  logic [hci_ecc_pkg::DataWidth-1:0] data_i,
  input  logic [hci_ecc_pkg::EccWidth-1:0]  ecc_i,
  output logic [hci_ecc_pkg::DataWidth-1:0] data_o,
  output logic [hci_ecc_pkg::EccWidth-1:0]  syndrome_o,
  output hci_ecc_pkg::ecc_err_e             err_o
);

  logic [hci_ecc_pkg::EccWidth-1:0] syndrome;

  // recompute check bits and compare against the received ones
  always_comb begin
    for (int k = 0; k < hci_ecc_pkg::EccWidth; k++) begin
      syndrome[k] = ecc_i[k] ^ (^(data_i & hci_ecc_pkg::EccMask[k]));
    end
  end

  // flip the data bit whose column equals the syndrome
  // a single check bit error has weight 1 and hits no data column
  always_comb begin
    logic [hci_ecc_pkg::EccWidth-1:0] col;
    data_o = data_i;
    col    = '0;
    for (int j = 0; j < hci_ecc_pkg::DataWidth; j++) begin
      for (int k = 0; k < hci_ecc_pkg::EccWidth; k++) begin
        col[k] = hci_ecc_pkg::EccMask[k][j];
      end
      if (syndrome == col) begin
        data_o[j] = ~data_i[j];
      end
    end
  end

  // odd weight means one flipped bit, even weight means two
  always_comb begin
    if (syndrome == '0) begin
      err_o = hci_ecc_pkg::ErrNone;
    end else if (^syndrome) begin
      err_o = hci_ecc_pkg::ErrCorr;
    end else begin
      err_o = hci_ecc_pkg::ErrUncorr;
    end
  end

  assign syndrome_o = syndrome;

endmodule

`default_nettype wire

// File: design/hci_mem_ecc_dec.sv
`timescale 1ns/1ps
`default_nettype none

// ecc boundary between the protected bus and the plain bank bus
// purely combinational, registering happens in the pipe stages around it
module hci_mem_ecc_dec (
  input  hci_ecc_pkg::ecc_req_t bus_req_i,
  output hci_ecc_pkg::ecc_rsp_t bus_rsp_o,
  output hci_ecc_pkg::mem_req_t mem_req_o,
  input  logic                  mem_gnt_i,
  input  hci_ecc_pkg::mem_rsp_t mem_rsp_i,
  output hci_ecc_pkg::ecc_evt_t evt_o
);

  logic [hci_ecc_pkg::DataWidth-1:0] data_fixed;
  logic [hci_ecc_pkg::EccWidth-1:0]  syndrome;
  hci_ecc_pkg::ecc_err_e             err;
  logic [hci_ecc_pkg::EccWidth-1:0]  r_ecc;
  logic                              wr_acc;

  // check the incoming write data
  secded_39_32_dec i_dec (
    .data_i     ( bus_req_i.data ),
    .ecc_i      ( bus_req_i.ecc  ),
    .data_o     ( data_fixed     ),
    .syndrome_o ( syndrome       ),
    .err_o      ( err            )
  );

  // fresh check bits for read data on the way back
  secded_39_32_enc i_enc (
    .data_i ( mem_rsp_i.r_data ),
    .ecc_o  ( r_ecc            )
  );

  // request side, check bits stripped here
  assign mem_req_o.req = bus_req_i.req;
  assign mem_req_o.add = bus_req_i.add;
  assign mem_req_o.wen = bus_req_i.wen;
  assign mem_req_o.be  = bus_req_i.be;
  // only a single error gets repaired
  // a double error is stored as received and flagged
  assign mem_req_o.data = (err == hci_ecc_pkg::ErrCorr) ? data_fixed : bus_req_i.data;

  // response side
  assign bus_rsp_o.gnt     = mem_gnt_i;
  assign bus_rsp_o.r_valid = mem_rsp_i.r_valid;
  assign bus_rsp_o.r_data  = mem_rsp_i.r_data;
  assign bus_rsp_o.r_ecc   = r_ecc;

  // reads carry no meaningful data field
  // so only accepted writes report a decode result
  assign wr_acc = bus_req_i.req & mem_gnt_i & ~bus_req_i.wen;

  assign evt_o.valid    = wr_acc;
  assign evt_o.err      = err;
  assign evt_o.syndrome = syndrome;
  assign evt_o.add      = bus_req_i.add;

endmodule

`default_nettype wire

// File: design/hci_mem_pipe.sv
`timescale 1ns/1ps
`default_nettype none

// one-cycle valid-qualified register stage
module hci_mem_pipe #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // valid is control, cleared by reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // payload only moves with a valid beat
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// File: design/hci_mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

// single-port sram bank, one-cycle read latency
// clears itself word by word after reset before granting anything
module hci_mem_bank (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  hci_ecc_pkg::mem_req_t req_i,
  output logic                  gnt_o,
  output hci_ecc_pkg::mem_rsp_t rsp_o
);

  logic [hci_ecc_pkg::DataWidth-1:0] mem_q [hci_ecc_pkg::BankDepth];
  logic [hci_ecc_pkg::IdxWidth-1:0]  init_ptr_q;
  logic                              init_done_q;
  logic [hci_ecc_pkg::IdxWidth-1:0]  idx;
  logic                              acc_wr;
  logic                              acc_rd;
  logic                              r_valid_q;
  logic [hci_ecc_pkg::DataWidth-1:0] r_data_q;

  // word index from the byte address
  assign idx = req_i.add[hci_ecc_pkg::AddrLsb +: hci_ecc_pkg::IdxWidth];

  // grant only once the sweep is over
  assign gnt_o  = init_done_q;
  assign acc_wr = req_i.req & init_done_q & ~req_i.wen;
  assign acc_rd = req_i.req & init_done_q & req_i.wen;

  // init sweep, BankDepth cycles
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      init_ptr_q  <= '0;
      init_done_q <= 1'b0;
    end else if (!init_done_q) begin
      init_ptr_q <= init_ptr_q + 1'b1;
      // depth is a power of two, so the last word is all ones
      if (init_ptr_q == '1) begin
        init_done_q <= 1'b1;
      end
    end
  end

  // storage, zero fill first then byte-enabled writes
  always_ff @(posedge clk_i) begin
    if (!init_done_q) begin
      mem_q[init_ptr_q] <= '0;
    end else if (acc_wr) begin
      for (int b = 0; b < hci_ecc_pkg::BeWidth; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

  // read response one cycle after acceptance
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= acc_rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_rd) begin
      r_data_q <= mem_q[idx];
    end
  end

  assign rsp_o = '{r_valid: r_valid_q, r_data: r_data_q};

endmodule

`default_nettype wire

// File: design/hci_ecc_err_stat.sv
`timescale 1ns/1ps
`default_nettype none

// ecc error statistics, read by software over apb
module hci_ecc_err_stat (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  hci_ecc_pkg::ecc_evt_t                evt_i,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [hci_ecc_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [hci_ecc_pkg::ApbDataWidth-1:0] pwdata_i,
  output logic [hci_ecc_pkg::ApbDataWidth-1:0] prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o
);

  logic [hci_ecc_pkg::CntWidth-1:0]  corr_cnt_q;
  logic [hci_ecc_pkg::CntWidth-1:0]  uncorr_cnt_q;
  logic [hci_ecc_pkg::EccWidth-1:0]  last_syn_q;
  logic [hci_ecc_pkg::AddrWidth-1:0] last_addr_q;
  logic                              apb_acc;
  logic                              clear;
  logic                              addr_hit;
  logic                              evt_corr;
  logic                              evt_uncorr;

  // access phase of a transfer, never stretched
  assign apb_acc  = psel_i & penable_i;
  assign pready_o = apb_acc;

  // clear is a write to RegClear, write data is ignored
  assign clear = apb_acc & pwrite_i & (paddr_i == hci_ecc_pkg::RegClear);

  assign evt_corr   = evt_i.valid & (evt_i.err == hci_ecc_pkg::ErrCorr);
  assign evt_uncorr = evt_i.valid & (evt_i.err == hci_ecc_pkg::ErrUncorr);

  // counters saturate, clear takes priority over a same-cycle event
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      corr_cnt_q   <= '0;
      uncorr_cnt_q <= '0;
      last_syn_q   <= '0;
      last_addr_q  <= '0;
    end else if (clear) begin
      corr_cnt_q   <= '0;
      uncorr_cnt_q <= '0;
      last_syn_q   <= '0;
      last_addr_q  <= '0;
    end else begin
      if (evt_corr && corr_cnt_q != '1) begin
        corr_cnt_q <= corr_cnt_q + 1'b1;
      end
      if (evt_uncorr && uncorr_cnt_q != '1) begin
        uncorr_cnt_q <= uncorr_cnt_q + 1'b1;
      end
      // keep the most recent faulty write
      if (evt_corr || evt_uncorr) begin
        last_syn_q  <= evt_i.syndrome;
        last_addr_q <= evt_i.add;
      end
    end
  end

  // read mux, zero-extended fields
  always_comb begin
    prdata_o = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      hci_ecc_pkg::RegCorrCnt:   prdata_o[hci_ecc_pkg::CntWidth-1:0]  = corr_cnt_q;
      hci_ecc_pkg::RegUncorrCnt: prdata_o[hci_ecc_pkg::CntWidth-1:0]  = uncorr_cnt_q;
      hci_ecc_pkg::RegLastSyn:   prdata_o[hci_ecc_pkg::EccWidth-1:0]  = last_syn_q;
      hci_ecc_pkg::RegLastAddr:  prdata_o[hci_ecc_pkg::AddrWidth-1:0] = last_addr_q;
      // clear reads back as zero
      hci_ecc_pkg::RegClear:     prdata_o = '0;
      default:                   addr_hit = 1'b0;
    endcase
  end

  // status registers are read-only, only RegClear accepts a write
  assign pslverr_o = apb_acc &
                     (~addr_hit | (pwrite_i & (paddr_i != hci_ecc_pkg::RegClear)));

endmodule

`default_nettype wire

// File: design/hci_ecc_mem_tile.sv
`timescale 1ns/1ps
`default_nettype none

// ecc protected memory tile
// decode -> bank -> response register + re-encode
module hci_ecc_mem_tile (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  hci_ecc_pkg::ecc_req_t                bus_req_i,
  output hci_ecc_pkg::ecc_rsp_t                bus_rsp_o,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [hci_ecc_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [hci_ecc_pkg::ApbDataWidth-1:0] pwdata_i,
  output logic [hci_ecc_pkg::ApbDataWidth-1:0] prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o
);

  hci_ecc_pkg::mem_req_t mem_req;
  logic                  mem_gnt;
  hci_ecc_pkg::mem_rsp_t bank_rsp;
  logic                  rsp_valid_q;
  hci_ecc_pkg::mem_rsp_t rsp_data_q;
  hci_ecc_pkg::mem_rsp_t rsp_q;
  hci_ecc_pkg::ecc_evt_t evt;
  logic                  evt_valid_q;
  hci_ecc_pkg::ecc_evt_t evt_data_q;
  hci_ecc_pkg::ecc_evt_t evt_q;

  // stage 1, check and strip
  hci_mem_ecc_dec i_ecc_dec (
    .bus_req_i ( bus_req_i ), .bus_rsp_o ( bus_rsp_o ), .mem_req_o ( mem_req ),
    .mem_gnt_i ( mem_gnt   ), .mem_rsp_i ( rsp_q     ), .evt_o     ( evt     )
  );

  // stage 2, storage
  hci_mem_bank i_bank (
    .clk_i ( clk_i ), .arst_n_i ( arst_n_i ), .req_i ( mem_req ),
    .gnt_o ( mem_gnt ), .rsp_o ( bank_rsp )
  );

  // stage 3, read data register ahead of re-encode
  hci_mem_pipe #(.payload_t(hci_ecc_pkg::mem_rsp_t)) i_rsp_pipe (
    .clk_i ( clk_i ), .arst_n_i ( arst_n_i ), .valid_i ( bank_rsp.r_valid ),
    .data_i ( bank_rsp ), .valid_o ( rsp_valid_q ), .data_o ( rsp_data_q )
  );

  // the stored valid field goes stale, the pipe valid replaces it
  assign rsp_q = '{r_valid: rsp_valid_q, r_data: rsp_data_q.r_data};

  // decode events, registered once before counting
  hci_mem_pipe #(.payload_t(hci_ecc_pkg::ecc_evt_t)) i_evt_pipe (
    .clk_i ( clk_i ), .arst_n_i ( arst_n_i ), .valid_i ( evt.valid ),
    .data_i ( evt ), .valid_o ( evt_valid_q ), .data_o ( evt_data_q )
  );

  assign evt_q = '{valid: evt_valid_q, err: evt_data_q.err,
                   syndrome: evt_data_q.syndrome, add: evt_data_q.add};

  hci_ecc_err_stat i_err_stat (
    .clk_i ( clk_i ), .arst_n_i ( arst_n_i ), .evt_i ( evt_q ),
    .psel_i ( psel_i ), .penable_i ( penable_i ), .pwrite_i ( pwrite_i ),
    .paddr_i ( paddr_i ), .pwdata_i ( pwdata_i ), .prdata_o ( prdata_o ),
    .pready_o ( pready_o ), .pslverr_o ( pslverr_o )
  );

endmodule

`default_nettype wire

// File: dv/hci_ecc_mem_sva.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the tile's protected memory bus
module hci_ecc_mem_sva (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input hci_ecc_pkg::ecc_req_t bus_req_i,
  input hci_ecc_pkg::ecc_rsp_t bus_rsp_i
);

  // failed assertions so far
  int unsigned fail_cnt = 0;
  logic        rd_acc;

  // a read is accepted when req and gnt meet with wen high
  assign rd_acc = bus_req_i.req & bus_rsp_i.gnt & bus_req_i.wen;

  // every accepted read answers exactly two cycles later
  rd_latency_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_acc |-> ##2 bus_rsp_i.r_valid)
    else begin
      fail_cnt++;
      $error("read response missing two cycles after acceptance");
    end

  // no response without a read two cycles earlier
  no_spurious_rsp_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_rsp_i.r_valid |-> $past(rd_acc, 2))
    else begin
      fail_cnt++;
      $error("read response without an accepted read");
    end

  // nothing granted or returned while in reset
  reset_quiet_a: assert property (@(posedge clk_i)
    !arst_n_i |-> (!bus_rsp_i.gnt && !bus_rsp_i.r_valid))
    else begin
      fail_cnt++;
      $error("gnt or r_valid high during reset");
    end

  // initiator holds a pending request unchanged
  req_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (bus_req_i.req && !bus_rsp_i.gnt) |=> $stable(bus_req_i))
    else begin
      fail_cnt++;
      $error("pending request changed before it was granted");
    end

endmodule

bind hci_ecc_mem_tile hci_ecc_mem_sva sva_i (
  .clk_i     ( clk_i     ),
  .arst_n_i  ( arst_n_i  ),
  .bus_req_i ( bus_req_i ),
  .bus_rsp_i ( bus_rsp_o )
);

`default_nettype wire

// File: dv/tb_hci_ecc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hci_ecc_mem;

  logic                                 clk = 1'b0;
  logic                                 arst_n;
  hci_ecc_pkg::ecc_req_t                bus_req;
  hci_ecc_pkg::ecc_rsp_t                bus_rsp;
  logic                                 psel;
  logic                                 penable;
  logic                                 pwrite;
  logic [hci_ecc_pkg::ApbAddrWidth-1:0] paddr;
  logic [hci_ecc_pkg::ApbDataWidth-1:0] pwdata;
  logic [hci_ecc_pkg::ApbDataWidth-1:0] prdata;
  logic                                 pready;
  logic                                 pslverr;

  // expected bank contents, all zero after the init sweep
  logic [31:0] model [hci_ecc_pkg::BankDepth] = '{default: '0};
  int unsigned exp_corr = 0;
  int unsigned exp_uncorr = 0;
  int unsigned err_cnt = 0;
  int unsigned timeout_cnt = 0;
  int unsigned gnt_wait;

  // 10 ns clock
  always #5 clk = ~clk;

  hci_ecc_mem_tile dut_i (
    .clk_i     ( clk     ), .arst_n_i  ( arst_n  ),
    .bus_req_i ( bus_req ), .bus_rsp_o ( bus_rsp ),
    .psel_i    ( psel    ), .penable_i ( penable ), .pwrite_i  ( pwrite  ),
    .paddr_i   ( paddr   ), .pwdata_i  ( pwdata  ), .prdata_o  ( prdata  ),
    .pready_o  ( pready  ), .pslverr_o ( pslverr )
  );

  // reference check bits, xor of the mask columns of every set data bit
  function automatic logic [6:0] calc_ecc(input logic [31:0] data);
    logic [6:0] ecc;
    ecc = '0;
    for (int j = 0; j < 32; j++) begin
      if (data[j]) begin
        for (int k = 0; k < 7; k++) begin
          ecc[k] = ecc[k] ^ hci_ecc_pkg::EccMask[k][j];
        end
      end
    end
    return ecc;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    assert (got === exp) else begin
      err_cnt++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // hold req until granted, then drop it on the accepting edge
  task automatic wait_gnt();
    int n;
    n = 0;
    @(posedge clk);
    while (!bus_rsp.gnt && n < 1000) begin
      n++;
      @(posedge clk);
    end
    if (!bus_rsp.gnt) begin
      $display("timeout: request was never granted");
      timeout_cnt++;
    end
    gnt_wait = n;
    bus_req.req <= 1'b0;
  endtask

  task automatic bus_write(input logic [7:0] idx, input logic [31:0] data,
                           input logic [6:0] ecc, input logic [3:0] be);
    @(posedge clk);
    bus_req.req  <= 1'b1;
    bus_req.add  <= 16'(idx) << 2;
    bus_req.wen  <= 1'b0;
    bus_req.be   <= be;
    bus_req.data <= data;
    bus_req.ecc  <= ecc;
    wait_gnt();
  endtask

  task automatic bus_read(input logic [7:0] idx, output logic [31:0] data,
                          output logic [6:0] ecc);
    int n;
    @(posedge clk);
    bus_req.req <= 1'b1;
    bus_req.add <= 16'(idx) << 2;
    bus_req.wen <= 1'b1;
    wait_gnt();
    n = 0;
    @(posedge clk);
    while (!bus_rsp.r_valid && n < 8) begin
      n++;
      @(posedge clk);
    end
    if (!bus_rsp.r_valid) begin
      $display("timeout: no read response");
      timeout_cnt++;
    end
    data = bus_rsp.r_data;
    ecc  = bus_rsp.r_ecc;
  endtask

  // read back one word against the model and its fresh check bits
  task automatic read_check(input logic [7:0] idx);
    logic [31:0] data;
    logic [6:0]  ecc;
    bus_read(idx, data, ecc);
    compare_value("r_data", model[idx], data);
    compare_value("r_ecc", 32'(calc_ecc(model[idx])), 32'(ecc));
  endtask

  // clean codeword, only enabled bytes land in the model
  task automatic write_clean(input logic [7:0] idx, input logic [31:0] data,
                             input logic [3:0] be);
    bus_write(idx, data, calc_ecc(data), be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // setup then access phase, completes when pready is seen
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int n;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    n = 0;
    @(posedge clk);
    while (!pready && n < 8) begin
      n++;
      @(posedge clk);
    end
    if (!pready) begin
      $display("timeout: apb transfer never completed");
      timeout_cnt++;
    end
    rdata = prdata;
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_expect(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    compare_value(name, exp, rdata);
    compare_value("pslverr", '0, 32'(err));
  endtask

  // send a codeword with one or two flipped bits, then check stats and storage
  task automatic write_flipped(input logic [7:0] idx, input logic [31:0] data, input int nflip);
    logic [38:0] cw;
    int          p;
    int          q;
    logic [6:0]  syn;
    cw = {calc_ecc(data), data};
    p  = $urandom_range(38, 0);
    // q never equals p
    q  = (p + 1 + $urandom_range(37, 0)) % 39;
    cw[p] = ~cw[p];
    if (nflip == 2) begin
      cw[q] = ~cw[q];
    end
    syn = calc_ecc(cw[31:0]) ^ cw[38:32];
    bus_write(idx, cw[31:0], cw[38:32], 4'hF);
    if (nflip == 1) begin
      model[idx] = data;
      exp_corr++;
    end else begin
      // double error is stored as received
      model[idx] = cw[31:0];
      exp_uncorr++;
    end
    apb_expect(hci_ecc_pkg::RegCorrCnt, exp_corr, "corr_cnt");
    apb_expect(hci_ecc_pkg::RegUncorrCnt, exp_uncorr, "uncorr_cnt");
    apb_expect(hci_ecc_pkg::RegLastSyn, 32'(syn), "last_syn");
    apb_expect(hci_ecc_pkg::RegLastAddr, 32'(idx) << 2, "last_addr");
    read_check(idx);
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [7:0]  idx;
    void'($urandom(32'hea14));
    arst_n  <= 1'b0;
    bus_req <= '0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    // first read lands in the init sweep and must wait it out
    // gnt is low for BankDepth cycles and req rises one cycle after release
    read_check(8'($urandom));
    assert (gnt_wait >= hci_ecc_pkg::BankDepth - 1) else begin
      err_cnt++;
      $display("read was granted before the bank finished clearing");
    end

    // clean writes with full byte enables
    repeat (16) begin
      idx = 8'($urandom);
      write_clean(idx, $urandom, 4'hF);
      read_check(idx);
    end
    // likely unwritten words, still zero
    repeat (4) read_check(8'($urandom));

    repeat (6) write_flipped(8'($urandom), $urandom, 1);
    repeat (4) write_flipped(8'($urandom), $urandom, 2);

    // partial writes, never all four bytes and never none
    repeat (8) begin
      idx = 8'($urandom);
      write_clean(idx, $urandom, 4'($urandom_range(14, 1)));
      read_check(idx);
    end

    // clear wipes all status registers
    apb_xfer(1'b1, hci_ecc_pkg::RegClear, 32'hffff_ffff, rdata, err);
    compare_value("pslverr", '0, 32'(err));
    exp_corr   = 0;
    exp_uncorr = 0;
    apb_expect(hci_ecc_pkg::RegCorrCnt, 0, "corr_cnt");
    apb_expect(hci_ecc_pkg::RegUncorrCnt, 0, "uncorr_cnt");
    apb_expect(hci_ecc_pkg::RegLastSyn, 0, "last_syn");
    apb_expect(hci_ecc_pkg::RegLastAddr, 0, "last_addr");
    // counters are read-only
    apb_xfer(1'b1, hci_ecc_pkg::RegCorrCnt, 32'h5, rdata, err);
    compare_value("pslverr", 32'h1, 32'(err));

    repeat (4) @(posedge clk);
    $display("errors: %0d value, %0d timeout, %0d assertion",
             err_cnt, timeout_cnt, dut_i.sva_i.fail_cnt);
    if (err_cnt + timeout_cnt + dut_i.sva_i.fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
design/hci_ecc_pkg.sv
design/secded_39_32_enc.sv
design/secded_39_32_dec.sv
design/hci_mem_ecc_dec.sv
design/hci_mem_pipe.sv
design/hci_mem_bank.sv
design/hci_ecc_err_stat.sv
design/hci_ecc_mem_tile.sv
dv/hci_ecc_mem_sva.sv
dv/tb_hci_ecc_mem.sv
